// File: logic/sm_fixed_pkg.sv
// ============================
// Fixed-point format for the softmax front end
// Q5.10 lane type, exp table sizes and table contents
// ============================

package sm_fixed_pkg;

    // ============================
    // Number format
    // ============================

    // Signed Q5.10 value, also used for the exp results
    typedef logic [15:0] q5_10_t;

    // Table address is taken from the top bits of a lane
    localparam int LUT_ADDR_W = 8;
    localparam int LUT_DEPTH  = 256;

    // Largest exp result, reached from entry 14 up to the sign boundary
    localparam q5_10_t EXP_SAT = 16'h7FFB;

    // Published sum width
    localparam int SUM_OUT_W = 32;

    // ============================
    // Exp table
    // ============================

    // Entry for one table address
    // Upper half of the address space holds negative inputs
    function automatic q5_10_t exp_lut_value(input logic [LUT_ADDR_W-1:0] addr);
        q5_10_t value;
        case (addr)
            // Rising region, exp of small positive inputs
            8'd0:   value = 16'h0400;
            8'd1:   value = 16'h0522;
            8'd2:   value = 16'h0698;
            8'd3:   value = 16'h0877;
            8'd4:   value = 16'h0ADF;
            8'd5:   value = 16'h0DF6;
            8'd6:   value = 16'h11ED;
            8'd7:   value = 16'h1704;
            8'd8:   value = 16'h1D8E;
            8'd9:   value = 16'h25F3;
            8'd10:  value = 16'h30BA;
            8'd11:  value = 16'h3E92;
            8'd12:  value = 16'h5057;
            8'd13:  value = 16'h6729;
            8'd14:  value = EXP_SAT;
            // Small region, exp of inputs just below zero
            8'd229: value = 16'h0001;
            8'd230: value = 16'h0001;
            8'd231: value = 16'h0001;
            8'd232: value = 16'h0002;
            8'd233: value = 16'h0003;
            8'd234: value = 16'h0004;
            8'd235: value = 16'h0005;
            8'd236: value = 16'h0006;
            8'd237: value = 16'h0008;
            8'd238: value = 16'h000B;
            8'd239: value = 16'h000E;
            8'd240: value = 16'h0012;
            8'd241: value = 16'h0018;
            8'd242: value = 16'h001E;
            8'd243: value = 16'h0027;
            8'd244: value = 16'h0032;
            8'd245: value = 16'h0041;
            8'd246: value = 16'h0054;
            8'd247: value = 16'h006B;
            8'd248: value = 16'h008A;
            8'd249: value = 16'h00B1;
            8'd250: value = 16'h00E4;
            8'd251: value = 16'h0125;
            8'd252: value = 16'h0178;
            8'd253: value = 16'h01E3;
            8'd254: value = 16'h026D;
            8'd255: value = 16'h031D;
            // Large positive inputs saturate, large negative ones underflow
            default: begin
                if (int'(addr) < LUT_DEPTH / 2) begin
                    value = EXP_SAT;
                end else begin
                    value = '0;
                end
            end
        endcase
        return value;
    endfunction

endpackage

// File: logic/sm_pipe_pkg.sv
// ============================
// Pipeline geometry and stage types
// ============================

package sm_pipe_pkg;

    // ============================
    // Geometry
    // ============================

    localparam int LANES       = 16;
    localparam int TREE_LEVELS = 4;

    // One carry bit per adder level
    localparam int SUM_W = $bits(sm_fixed_pkg::q5_10_t) + TREE_LEVELS;

    // ============================
    // Stage types
    // ============================

    // One vector of lane values, lane 0 in the low bits
    typedef sm_fixed_pkg::q5_10_t [LANES-1:0] lane_vec_t;

    // Registered lookup result with its strobe
    typedef struct packed {
        logic      valid;
        lane_vec_t exp_vec;
    } exp_stage_t;

endpackage

// File: logic/exp_lut.sv
// ============================
// Exp table lookup stage
// One table read per lane, result registered
// ============================

`timescale 1ns/1ns

module exp_lut #(
    parameter int LANES = sm_pipe_pkg::LANES
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid_in,
    input  sm_pipe_pkg::lane_vec_t input_vector,
    output sm_pipe_pkg::exp_stage_t lut_stage
);

    localparam int VAL_W = $bits(sm_fixed_pkg::q5_10_t);

    sm_pipe_pkg::lane_vec_t lut_data;
    sm_pipe_pkg::lane_vec_t stage_data;
    logic                   stage_valid;

    // Address is the integer part plus the top fraction bits
    always_comb begin
        lut_data = '0;
        for (int i = 0; i < LANES; i++) begin
            lut_data[i] = sm_fixed_pkg::exp_lut_value(
                input_vector[i][VAL_W-1 -: sm_fixed_pkg::LUT_ADDR_W]);
        end
    end

    // Strobe follows valid_in every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= valid_in;
        end
    end

    // Lookup data only moves with a valid input
    always_ff @(posedge clk) begin
        if (valid_in) begin
            stage_data <= lut_data;
        end
    end

    assign lut_stage = '{valid: stage_valid, exp_vec: stage_data};

endmodule

// File: logic/sum_tree.sv
// ============================
// Pipelined adder tree
// Sums all lanes, one pair level per clock
// ============================

`timescale 1ns/1ns

module sum_tree #(
    parameter int LANES       = sm_pipe_pkg::LANES,
    parameter int TREE_LEVELS = sm_pipe_pkg::TREE_LEVELS
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  sm_pipe_pkg::exp_stage_t       lut_stage,
    output logic                          sum_valid,
    output logic [sm_pipe_pkg::SUM_W-1:0] sum
);

    localparam int VAL_W = $bits(sm_fixed_pkg::q5_10_t);

    // ============================
    // Adder levels
    // ============================

    for (genvar l = 1; l <= TREE_LEVELS; l++) begin : g_level
        // Half the nodes of the level above, one bit wider
        localparam int NODES = LANES >> l;
        localparam int W     = VAL_W + l;

        logic [W-2:0] operand [2*NODES];
        logic [W-1:0] node [NODES];
        logic         src_valid;
        logic         valid;

        if (l == 1) begin : g_src
            assign src_valid = lut_stage.valid;
            for (genvar n = 0; n < 2*NODES; n++) begin : g_op
                assign operand[n] = lut_stage.exp_vec[n];
            end
        end else begin : g_src
            assign src_valid = g_level[l-1].valid;
            for (genvar n = 0; n < 2*NODES; n++) begin : g_op
                assign operand[n] = g_level[l-1].node[n];
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                valid <= 1'b0;
            end else begin
                valid <= src_valid;
            end
        end

        // Node holds its sum through bubbles
        always_ff @(posedge clk) begin
            if (src_valid) begin
                for (int n = 0; n < NODES; n++) begin
                    node[n] <= operand[2*n] + operand[2*n+1];
                end
            end
        end
    end

    // Last level is a single node
    assign sum_valid = g_level[TREE_LEVELS].valid;
    assign sum       = g_level[TREE_LEVELS].node[0];

    // ============================
    // Checks
    // ============================

    // Tree only covers a power-of-two lane count
    a_lane_count: assert property (
        @(posedge clk) LANES == (1 << TREE_LEVELS)
    ) else $error("sum_tree: LANES %0d does not fit %0d levels", LANES, TREE_LEVELS);

    // Sum bounded by every lane saturated
    a_sum_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        sum_valid |-> (sum <= LANES * sm_fixed_pkg::EXP_SAT)
    ) else $error("sum_tree: sum %h above saturated total", sum);

endmodule

// File: logic/exp_delay_line.sv
// ============================
// Exp vector delay line
// Carries the lookup vector beside the adder tree
// ============================

`timescale 1ns/1ns

module exp_delay_line #(
    parameter int DEPTH = sm_pipe_pkg::TREE_LEVELS
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  sm_pipe_pkg::exp_stage_t lut_stage,
    output sm_pipe_pkg::lane_vec_t  exp_vector
);

    // valid_q[k] mirrors the strobe of tree level k+1
    logic [DEPTH-1:0]       valid_q;
    sm_pipe_pkg::lane_vec_t data_q [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= lut_stage.valid;
            for (int k = 1; k < DEPTH; k++) begin
                valid_q[k] <= valid_q[k-1];
            end
        end
    end

    // Each copy advances only with its level, same as the tree nodes
    always_ff @(posedge clk) begin
        if (lut_stage.valid) begin
            data_q[0] <= lut_stage.exp_vec;
        end
        for (int k = 1; k < DEPTH; k++) begin
            if (valid_q[k-1]) begin
                data_q[k] <= data_q[k-1];
            end
        end
    end

    assign exp_vector = data_q[DEPTH-1];

    a_no_x_entry: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_q[DEPTH-1] |-> !$isunknown(data_q[0])
    ) else $error("exp_delay_line: output valid with unknown entry data");

endmodule

// File: logic/softmax_frontend.sv
// ============================
// Softmax front end top level
// Exp lookup, lane sum and aligned output register
// ============================

`timescale 1ns/1ns

module softmax_frontend (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 valid_in,
    input  sm_pipe_pkg::lane_vec_t               input_vector,
    output logic                                 valid_out,
    output sm_pipe_pkg::lane_vec_t               exp_values,
    output logic [sm_fixed_pkg::SUM_OUT_W-1:0]   exp_sum
);

    localparam int PAD_W = sm_fixed_pkg::SUM_OUT_W - sm_pipe_pkg::SUM_W;

    sm_pipe_pkg::exp_stage_t         lut_stage;
    logic                            sum_valid;
    logic [sm_pipe_pkg::SUM_W-1:0]   sum;
    sm_pipe_pkg::lane_vec_t          exp_delayed;

    // ============================
    // Pipeline stages
    // ============================

    exp_lut #(
        .LANES (sm_pipe_pkg::LANES)
    ) exp_lut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_in     (valid_in),
        .input_vector (input_vector),
        .lut_stage    (lut_stage)
    );

    sum_tree #(
        .LANES       (sm_pipe_pkg::LANES),
        .TREE_LEVELS (sm_pipe_pkg::TREE_LEVELS)
    ) sum_tree_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .lut_stage (lut_stage),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    // Depth matches the tree so the vector meets its sum
    exp_delay_line #(
        .DEPTH (sm_pipe_pkg::TREE_LEVELS)
    ) exp_delay_line_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .lut_stage  (lut_stage),
        .exp_vector (exp_delayed)
    );

    // ============================
    // Output register
    // ============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out  <= 1'b0;
            exp_values <= '0;
            exp_sum    <= '0;
        end else begin
            valid_out <= sum_valid;
            // Outputs hold between results
            if (sum_valid) begin
                exp_values <= exp_delayed;
                exp_sum    <= {{PAD_W{1'b0}}, sum};
            end
        end
    end

endmodule

// File: tb/softmax_frontend_tb.sv
// ============================
// Softmax front end testbench
// Reference model, in-order compare and latency checks
// ============================

`timescale 1ns/1ns

module softmax_frontend_tb;

    localparam int LANES       = sm_pipe_pkg::LANES;
    localparam int WAIT_LIMIT  = 50;
    localparam int EXP_LATENCY = 6;

    // Expected outputs for one input vector
    typedef struct packed {
        sm_pipe_pkg::lane_vec_t values;
        logic [31:0]            sum;
    } exp_result_t;

    logic                   clk;
    logic                   rst_n;
    logic                   valid_in;
    sm_pipe_pkg::lane_vec_t input_vector;
    logic                   valid_out;
    sm_pipe_pkg::lane_vec_t exp_values;
    logic [31:0]            exp_sum;

    exp_result_t            expected_q [$];
    exp_result_t            exp_r;
    sm_pipe_pkg::lane_vec_t held_values;
    logic [31:0]            held_sum;
    logic [31:0]            lfsr_state;
    int                     mismatch_count;
    int                     other_count;

    softmax_frontend softmax_frontend_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_in     (valid_in),
        .input_vector (input_vector),
        .valid_out    (valid_out),
        .exp_values   (exp_values),
        .exp_sum      (exp_sum)
    );

    always #2 clk = ~clk;

    // ============================
    // Helpers
    // ============================

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] result;
        logic        lsb;
        result = '0;
        for (int b = 0; b < count; b++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'h80200003;
            end
            result = {result[30:0], lsb};
        end
        return result;
    endfunction

    // Table lookup on the top 8 bits of each lane, then the plain total
    function automatic exp_result_t reference_result(input sm_pipe_pkg::lane_vec_t vec);
        exp_result_t r;
        logic [31:0] total;
        total = '0;
        for (int i = 0; i < LANES; i++) begin
            r.values[i] = sm_fixed_pkg::exp_lut_value(vec[i][15:8]);
            total = total + 32'(r.values[i]);
        end
        r.sum = total;
        return r;
    endfunction

    task automatic send_item(input sm_pipe_pkg::lane_vec_t vec, input exp_result_t exp);
        @(posedge clk);
        valid_in     <= 1'b1;
        input_vector <= vec;
        expected_q.push_back(exp);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            valid_in <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (expected_q.size() == 0) else begin
            $display("Timed out waiting for %0d pending results", expected_q.size());
            other_count++;
        end
    endtask

    // ============================
    // Output compare
    // ============================

    always @(negedge clk) begin
        if (rst_n) begin
            if (valid_out) begin
                assert (expected_q.size() != 0) else begin
                    $display("valid_out went high with no result expected");
                    other_count++;
                end
                if (expected_q.size() != 0) begin
                    exp_r = expected_q.pop_front();
                    assert (exp_values == exp_r.values) else begin
                        $display("MISMATCH exp_values: got %h expected %h",
                                 exp_values, exp_r.values);
                        mismatch_count++;
                    end
                    assert (exp_sum == exp_r.sum) else begin
                        $display("MISMATCH exp_sum: got %h expected %h", exp_sum, exp_r.sum);
                        mismatch_count++;
                    end
                end
                held_values = exp_values;
                held_sum    = exp_sum;
            end else begin
                // Outputs must not move between pulses
                assert (exp_values == held_values) else begin
                    $display("MISMATCH exp_values: got %h expected %h", exp_values, held_values);
                    mismatch_count++;
                end
                assert (exp_sum == held_sum) else begin
                    $display("MISMATCH exp_sum: got %h expected %h", exp_sum, held_sum);
                    mismatch_count++;
                end
            end
        end
    end

    // ============================
    // Stimulus
    // ============================

    initial begin
        sm_pipe_pkg::lane_vec_t vec;
        exp_result_t            exp;
        int                     cycles;

        clk            = 1'b0;
        rst_n          = 1'b0;
        valid_in       = 1'b0;
        input_vector   = '0;
        lfsr_state     = 32'h35277ce4;
        mismatch_count = 0;
        other_count    = 0;
        held_values    = '0;
        held_sum       = '0;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycles(3);

        // Reset state before any input
        @(negedge clk);
        assert (valid_out == 1'b0) else begin
            $display("MISMATCH valid_out: got %h expected %h", valid_out, 1'b0);
            mismatch_count++;
        end
        assert (exp_values == '0 && exp_sum == '0) else begin
            $display("MISMATCH exp_values/exp_sum: got %h/%h expected zero", exp_values, exp_sum);
            mismatch_count++;
        end

        // Single vector and its latency
        for (int i = 0; i < LANES; i++) begin
            vec[i] = 16'(i * 16'h0123);
        end
        send_item(vec, reference_result(vec));
        @(posedge clk);
        valid_in <= 1'b0;
        cycles = 1;
        while (cycles < WAIT_LIMIT) begin
            @(negedge clk);
            if (valid_out) begin
                break;
            end
            @(posedge clk);
            cycles++;
        end
        assert (cycles == EXP_LATENCY) else begin
            $display("Single vector took %0d cycles to reach valid_out, expected %0d",
                     cycles, EXP_LATENCY);
            other_count++;
        end
        wait_drain();

        // Every table address, back to back
        for (int j = 0; j < 16; j++) begin
            for (int i = 0; i < LANES; i++) begin
                vec[i] = {8'(j * 16 + i), 8'(i * 17)};
            end
            send_item(vec, reference_result(vec));
        end
        idle_cycles(1);
        wait_drain();

        // Saturated lanes
        for (int i = 0; i < LANES; i++) begin
            vec[i]        = {8'd14, 8'(rand_bits(8))};
            exp.values[i] = sm_fixed_pkg::EXP_SAT;
        end
        exp.sum = LANES * 32'(sm_fixed_pkg::EXP_SAT);
        send_item(vec, exp);
        // Zero region
        for (int i = 0; i < LANES; i++) begin
            vec[i] = {8'(128 + i * 6), 8'(rand_bits(8))};
        end
        exp = '0;
        send_item(vec, exp);
        idle_cycles(1);
        wait_drain();

        // Random traffic with gaps
        for (int n = 0; n < 200; n++) begin
            for (int i = 0; i < LANES; i++) begin
                vec[i] = 16'(rand_bits(16));
            end
            send_item(vec, reference_result(vec));
            idle_cycles(int'(rand_bits(2)));
        end
        idle_cycles(1);
        wait_drain();
        idle_cycles(4);

        $display("Errors: mismatches %0d, other failures %0d", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
logic/sm_fixed_pkg.sv
logic/sm_pipe_pkg.sv
logic/exp_lut.sv
logic/sum_tree.sv
logic/exp_delay_line.sv
logic/softmax_frontend.sv
tb/softmax_frontend_tb.sv
